// ==== fog_params.svh ====
`ifndef FOG_PARAMS_SVH
`define FOG_PARAMS_SVH

// Converter widths
`define FOG_ADC_W 14 // Parallel ADC bus, two's complement
`define FOG_DAC_W 16 // Parallel DAC bus to the MIOC driver

// Loop arithmetic
`define FOG_ACC_W 32 // Error, step and ramp words
`define FOG_CNT_W 16 // Half-period and settling counters
`define FOG_SHIFT_W 5 // Covers every shift of a 32-bit word

// Readout path
`define FOG_FIFO_DEPTH 4 // Records buffered toward the host
`define FOG_CREDITS 2 // Credits held right after reset

`endif

// ==== fog_pkg.sv ====
`default_nettype none

`include "fog_params.svh"

package fog_pkg;

	typedef logic signed [`FOG_ADC_W-1:0] adc_sample_t; // Raw ADC sample
	typedef logic [`FOG_DAC_W-1:0] dac_code_t; // DAC code, wraps
	typedef logic signed [`FOG_ACC_W-1:0] loop_word_t; // Error, step, ramp
	typedef logic [`FOG_CNT_W-1:0] half_cnt_t; // Clocks within a half period
	typedef logic [`FOG_SHIFT_W-1:0] shift_t; // Gain shift selector

	typedef enum logic {
		MOD_HIGH, // Modulator at amp_h
		MOD_LOW // Modulator at amp_l
	} mod_phase_t;

	// Channel setup, held stable by the host while the loop runs
	typedef struct packed {
		half_cnt_t freq_cnt; // Half period in clocks
		half_cnt_t wait_cnt; // Settling clocks skipped per half
		dac_code_t amp_h; // High modulation level
		dac_code_t amp_l; // Low modulation level
		logic polarity; // 1 negates the error
		loop_word_t err_offset; // Added after polarity
		logic fb_on; // 0 selects const_step
		shift_t gain_sel_step; // Error to step gain
		loop_word_t const_step; // Open-loop step
		shift_t gain_sel_ramp; // Step to ramp gain
	} fog_cfg_t;

	typedef struct packed {
		loop_word_t step; // Rate step after update
		loop_word_t err; // Error that produced it
	} rate_rec_t;

endpackage

`default_nettype wire

// ==== fog_loop_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module fog_loop_ctrl (
	input wire i_clock_adc,
	input wire i_reset,
	input wire fog_pkg::fog_cfg_t i_cfg,
	output fog_pkg::mod_phase_t o_phase,
	output logic o_in_window,
	output logic o_period_end
);

	fog_pkg::half_cnt_t idx_q; // Clock index inside current half
	fog_pkg::half_cnt_t last_idx; // freq_cnt - 1
	fog_pkg::mod_phase_t phase_nxt;
	logic half_end; // Last clock of this half

	assign last_idx = i_cfg.freq_cnt - 1'b1; // Wraps for freq_cnt of 0
	assign half_end = (idx_q == last_idx);

	// Square-wave FSM, toggles at each half boundary
	always_comb begin
		phase_nxt = o_phase; // Hold inside the half
		if (half_end) begin
			case (o_phase)
				fog_pkg::MOD_HIGH: phase_nxt = fog_pkg::MOD_LOW;
				default: phase_nxt = fog_pkg::MOD_HIGH;
			endcase
		end
	end

	always_ff @(posedge i_clock_adc) begin
		if (i_reset) begin
			idx_q <= '0; // First clock after reset is index 0
			o_phase <= fog_pkg::MOD_HIGH; // Period opens on the high half
		end else begin
			o_phase <= phase_nxt;
			if (half_end) begin
				idx_q <= '0; // Restart for the next half
			end else begin
				idx_q <= idx_q + 1'b1;
			end
		end
	end

	// Samples before wait_cnt are still settling after the step
	assign o_in_window = (idx_q >= i_cfg.wait_cnt);

	// One strobe per period, on the final low-half clock
	assign o_period_end = half_end && (o_phase == fog_pkg::MOD_LOW);

endmodule

`default_nettype wire

// ==== fog_demod.sv ====
`timescale 1ns/1ns
`default_nettype none

module fog_demod (
	input wire i_clock_adc,
	input wire i_reset,
	input wire fog_pkg::fog_cfg_t i_cfg,
	input wire fog_pkg::adc_sample_t i_adc,
	input wire fog_pkg::mod_phase_t i_phase,
	input wire i_in_window,
	input wire i_period_end,
	output fog_pkg::loop_word_t o_err,
	output logic o_err_valid
);

	fog_pkg::loop_word_t sample; // Sign-extended ADC value
	fog_pkg::loop_word_t add_h; // Contribution to high sum
	fog_pkg::loop_word_t add_l; // Contribution to low sum
	fog_pkg::loop_word_t acc_h_q; // High-half running sum
	fog_pkg::loop_word_t acc_l_q; // Low-half running sum
	fog_pkg::loop_word_t low_sum; // Low sum including this clock
	fog_pkg::loop_word_t diff; // High minus low
	fog_pkg::loop_word_t err_nxt; // Polarity and offset applied

	assign sample = fog_pkg::loop_word_t'(i_adc); // Signed cast extends sign
	assign add_h = (i_in_window && i_phase == fog_pkg::MOD_HIGH) ? sample : '0;
	assign add_l = (i_in_window && i_phase == fog_pkg::MOD_LOW) ? sample : '0;

	// Period end falls in the low half, so its sample joins the low sum
	assign low_sum = acc_l_q + add_l;
	assign diff = acc_h_q - low_sum;
	assign err_nxt = (i_cfg.polarity ? -diff : diff) + i_cfg.err_offset;

	always_ff @(posedge i_clock_adc) begin
		if (i_reset) begin
			acc_h_q <= '0;
			acc_l_q <= '0;
			o_err_valid <= 1'b0;
		end else begin
			o_err_valid <= i_period_end; // One clock behind the strobe
			if (i_period_end) begin
				acc_h_q <= '0; // Fresh sums for the next period
				acc_l_q <= '0;
			end else begin
				acc_h_q <= acc_h_q + add_h;
				acc_l_q <= acc_l_q + add_l;
			end
		end
	end

	// Error word, only meaningful with o_err_valid
	always_ff @(posedge i_clock_adc) begin
		if (i_period_end) begin
			o_err <= err_nxt;
		end
	end

endmodule

`default_nettype wire

// ==== fog_feedback.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "fog_params.svh"

module fog_feedback (
	input wire i_clock_adc,
	input wire i_reset,
	input wire fog_pkg::fog_cfg_t i_cfg,
	input wire fog_pkg::mod_phase_t i_phase,
	input wire fog_pkg::loop_word_t i_err,
	input wire i_err_valid,
	output fog_pkg::dac_code_t o_dac,
	output fog_pkg::rate_rec_t o_rec,
	output logic o_rec_valid
);

	fog_pkg::loop_word_t step_q; // Integrated rate step
	fog_pkg::loop_word_t ramp_q; // Serrodyne phase ramp
	fog_pkg::loop_word_t step_nxt;
	fog_pkg::loop_word_t ramp_nxt;
	fog_pkg::dac_code_t amp_sel; // Level of the current half

	// Closed loop integrates the scaled error, open loop forces a fixed step
	always_comb begin
		if (i_cfg.fb_on) begin
			step_nxt = step_q + (i_err >>> i_cfg.gain_sel_step); // Arithmetic shift
		end else begin
			step_nxt = i_cfg.const_step;
		end
		ramp_nxt = ramp_q + (step_nxt >>> i_cfg.gain_sel_ramp); // Uses new step
	end

	assign amp_sel = (i_phase == fog_pkg::MOD_HIGH) ? i_cfg.amp_h : i_cfg.amp_l;

	always_ff @(posedge i_clock_adc) begin
		if (i_reset) begin
			step_q <= '0;
			ramp_q <= '0;
			o_rec_valid <= 1'b0;
		end else begin
			o_rec_valid <= i_err_valid; // One record per error
			if (i_err_valid) begin
				step_q <= step_nxt;
				ramp_q <= ramp_nxt; // Ramp overflow wraps like 2pi reset
			end
		end
	end

	always_ff @(posedge i_clock_adc) begin
		// Ramp low bits plus modulation, modulo DAC range
		o_dac <= ramp_q[`FOG_DAC_W-1:0] + amp_sel;
		if (i_err_valid) begin
			o_rec.step <= step_nxt;
			o_rec.err <= i_err;
		end
	end

endmodule

`default_nettype wire

// ==== fog_rate_out.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "fog_params.svh"

module fog_rate_out (
	input wire i_clock_adc,
	input wire i_reset,
	input wire fog_pkg::rate_rec_t i_rec,
	input wire i_rec_valid,
	input wire i_credit,
	output fog_pkg::rate_rec_t o_rate,
	output logic o_rate_valid,
	output logic o_overflow
);

	localparam int PTR_W = (`FOG_FIFO_DEPTH > 1) ? $clog2(`FOG_FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(`FOG_FIFO_DEPTH + 1);
	localparam int CRED_W = $clog2(`FOG_CREDITS + 1);

	fog_pkg::rate_rec_t mem [`FOG_FIFO_DEPTH]; // Record storage
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] fill; // Records held
	logic [CRED_W-1:0] credit_cnt; // Credits granted by the host
	logic full;
	logic push;
	logic pop;

	// Pointer advance with wrap for any depth
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(`FOG_FIFO_DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign full = (fill == CNT_W'(`FOG_FIFO_DEPTH));
	assign push = i_rec_valid && !full; // Drop when full
	assign o_rate_valid = (fill != '0) && (credit_cnt != '0); // Needs data and credit
	assign pop = o_rate_valid; // Host takes every shown record
	assign o_rate = mem[rd_ptr]; // Head of FIFO

	always_ff @(posedge i_clock_adc) begin
		if (i_reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill <= '0;
			credit_cnt <= CRED_W'(`FOG_CREDITS); // Full credit pool
			o_overflow <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			case ({push, pop})
				2'b10: fill <= fill + 1'b1;
				2'b01: fill <= fill - 1'b1;
				default: fill <= fill; // Both or neither
			endcase
			// Returned credit and spent credit cancel out
			if (i_credit && !pop && credit_cnt != CRED_W'(`FOG_CREDITS)) begin
				credit_cnt <= credit_cnt + 1'b1;
			end else if (pop && !i_credit) begin
				credit_cnt <= credit_cnt - 1'b1;
			end
			if (i_rec_valid && full) begin
				o_overflow <= 1'b1; // Sticky until reset
			end
		end
	end

	always_ff @(posedge i_clock_adc) begin
		if (push) begin
			mem[wr_ptr] <= i_rec;
		end
	end

endmodule

`default_nettype wire

// ==== fog_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module fog_top (
	input wire i_clock_adc,
	input wire i_reset,
	input wire fog_pkg::fog_cfg_t i_cfg,
	input wire fog_pkg::adc_sample_t i_adc,
	input wire i_credit,
	output fog_pkg::dac_code_t o_dac,
	output fog_pkg::rate_rec_t o_rate,
	output logic o_rate_valid,
	output logic o_overflow
);

	fog_pkg::mod_phase_t phase; // Current modulation half
	logic in_window; // Settled part of the half
	logic period_end; // Last clock of a period
	fog_pkg::loop_word_t err;
	logic err_valid;
	fog_pkg::rate_rec_t rec;
	logic rec_valid;

	fog_loop_ctrl u_loop_ctrl (
		.i_clock_adc(i_clock_adc),
		.i_reset(i_reset),
		.i_cfg(i_cfg),
		.o_phase(phase),
		.o_in_window(in_window),
		.o_period_end(period_end)
	);

	fog_demod u_demod (
		.i_clock_adc(i_clock_adc),
		.i_reset(i_reset),
		.i_cfg(i_cfg),
		.i_adc(i_adc),
		.i_phase(phase),
		.i_in_window(in_window),
		.i_period_end(period_end),
		.o_err(err),
		.o_err_valid(err_valid)
	);

	fog_feedback u_feedback (
		.i_clock_adc(i_clock_adc),
		.i_reset(i_reset),
		.i_cfg(i_cfg),
		.i_phase(phase),
		.i_err(err),
		.i_err_valid(err_valid),
		.o_dac(o_dac), // Straight to the MIOC DAC
		.o_rec(rec),
		.o_rec_valid(rec_valid)
	);

	fog_rate_out u_rate_out (
		.i_clock_adc(i_clock_adc),
		.i_reset(i_reset),
		.i_rec(rec),
		.i_rec_valid(rec_valid),
		.i_credit(i_credit),
		.o_rate(o_rate),
		.o_rate_valid(o_rate_valid),
		.o_overflow(o_overflow)
	);

endmodule

`default_nettype wire

// ==== fog_asserts.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "fog_params.svh"

module fog_asserts (
	input wire i_clock_adc,
	input wire i_reset,
	input wire i_credit,
	input wire i_rate_valid,
	input wire [$clog2(`FOG_CREDITS + 1)-1:0] i_credit_cnt,
	input wire i_period_end
);

	int fail_cnt; // Read by the testbench at the end
	int held; // Credits granted by the host and not yet spent

	initial fail_cnt = 0;

	// Host-side view of the credit pool
	always_ff @(posedge i_clock_adc) begin
		if (i_reset) begin
			held <= `FOG_CREDITS;
		end else if (i_credit && !i_rate_valid) begin
			held <= (held < `FOG_CREDITS) ? held + 1 : held; // Extra credits are lost
		end else if (i_rate_valid && !i_credit) begin
			held <= held - 1;
		end
	end

	// A record leaves only against a held credit
	assert property (@(posedge i_clock_adc) disable iff (i_reset)
		i_rate_valid |-> (held > 0))
		else begin
			fail_cnt++;
			$error("rate record shown with no credit held");
		end

	assert property (@(posedge i_clock_adc) disable iff (i_reset)
		i_credit_cnt <= `FOG_CREDITS) // Pool capped at reset value
		else begin
			fail_cnt++;
			$error("credit count above its reset value");
		end

	assert property (@(posedge i_clock_adc) disable iff (i_reset)
		i_period_end |=> !i_period_end)
		else begin
			fail_cnt++;
			$error("period-end strobe wider than one clock");
		end

endmodule

bind fog_top fog_asserts u_asserts (
	.i_clock_adc(i_clock_adc),
	.i_reset(i_reset),
	.i_credit(i_credit),
	.i_rate_valid(o_rate_valid),
	.i_credit_cnt(u_rate_out.credit_cnt),
	.i_period_end(period_end)
);

`default_nettype wire

// ==== fog_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "fog_params.svh"

module fog_tb;

	typedef struct {
		string name;
		fog_pkg::fog_cfg_t cfg;
		int adc_h; // Settled level, high half
		int adc_l; // Settled level, low half
		int periods;
		int credit_gap; // Clocks between credits or 0 for none
		int exp_step; // Step after the last period
	} row_t;

	logic clock_adc;
	logic reset;
	fog_pkg::fog_cfg_t cfg_in;
	fog_pkg::adc_sample_t adc_in;
	logic credit_in;
	fog_pkg::dac_code_t dac_out;
	fog_pkg::rate_rec_t rate_out;
	logic rate_valid;
	logic overflow;

	row_t rows [5];
	string cur_name; // Row under test, for error lines
	integer seed;
	int n_checks;
	int n_errors;
	int budget; // Watchdog limit in clocks
	int r;

	fog_top u_dut (
		.i_clock_adc(clock_adc),
		.i_reset(reset),
		.i_cfg(cfg_in),
		.i_adc(adc_in),
		.i_credit(credit_in),
		.o_dac(dac_out),
		.o_rate(rate_out),
		.o_rate_valid(rate_valid),
		.o_overflow(overflow)
	);

	initial begin
		clock_adc = 1'b0;
		forever #5 clock_adc = ~clock_adc; // 100 MHz
	end

	initial begin
		wait (budget > 0);
		#(budget * 10);
		$display("Timeout: run went past its budget of %0d clocks", budget);
		$display("RESULT: FAIL");
		$finish;
	end

	function automatic fog_pkg::fog_cfg_t make_cfg(input int freq, input int settle,
		input int pol, input int off, input int fb, input int gs, input int cs, input int gr);
		fog_pkg::fog_cfg_t c;
		c = '0;
		c.freq_cnt = freq;
		c.wait_cnt = settle;
		c.amp_h = 16'h3000; // Quarter-wave levels
		c.amp_l = 16'hd000;
		c.polarity = pol[0];
		c.err_offset = off;
		c.fb_on = fb[0];
		c.gain_sel_step = gs;
		c.const_step = cs;
		c.gain_sel_ramp = gr;
		return c;
	endfunction

	task automatic check(input string what, input longint expv, input longint actv);
		n_checks++;
		if (expv != actv) begin
			n_errors++;
			$display("MISMATCH %s %s: expected %0d, actual %0d", cur_name, what, expv, actv);
		end
	endtask

	// Resets the DUT, then steps the loop model one clock at a time
	task automatic run_row(input row_t row);
		fog_pkg::rate_rec_t mq [$]; // Expected FIFO contents
		fog_pkg::rate_rec_t pend [$]; // Records still in the pipeline
		fog_pkg::loop_word_t pend_ramp [$];
		int pend_due [$]; // Clock of o_rec_valid
		fog_pkg::loop_word_t hsum, lsum, err, step, ramp, ramp_vis;
		fog_pkg::rate_rec_t rec;
		fog_pkg::dac_code_t dac_exp;
		int f, n, c, smp, credits, got, errs_before;
		logic hi, full, give, ovf, show;
		f = row.cfg.freq_cnt;
		n = row.periods * 2 * f + 7; // Tail drains the FIFO
		cur_name = row.name;
		errs_before = n_errors;
		cfg_in = row.cfg;
		reset = 1'b1;
		credit_in = 1'b0;
		adc_in = '0;
		repeat (3) @(posedge clock_adc);
		#1;
		reset = 1'b0;
		hsum = 0;
		lsum = 0;
		step = 0;
		ramp = 0;
		ramp_vis = 0;
		credits = `FOG_CREDITS;
		ovf = 1'b0;
		got = 0;
		dac_exp = row.cfg.amp_h;
		for (c = 0; c < n; c++) begin
			show = (mq.size() > 0) && (credits > 0);
			full = (mq.size() == `FOG_FIFO_DEPTH); // Before this clock's pop
			check("o_dac", dac_exp, dac_out);
			check("o_overflow", ovf, overflow);
			check("o_rate_valid", show, rate_valid);
			if (show) begin
				rec = mq.pop_front();
				check("record step", rec.step, rate_out.step);
				check("record err", rec.err, rate_out.err);
				got++;
			end
			if (pend_due.size() > 0 && pend_due[0] == c) begin
				pend_due.delete(0);
				ramp_vis = pend_ramp.pop_front(); // Ramp register now holds it
				rec = pend.pop_front();
				if (full) begin
					ovf = 1'b1; // Record lost
				end else begin
					mq.push_back(rec);
				end
			end
			give = (c >= n - 7) || (row.credit_gap > 0 && c % row.credit_gap == 0);
			credits = credits - int'(show) + int'(give);
			if (credits > `FOG_CREDITS) begin
				credits = `FOG_CREDITS;
			end
			hi = ((c / f) % 2) == 0;
			smp = hi ? row.adc_h : row.adc_l;
			if (c % f < row.cfg.wait_cnt) begin
				smp = smp + $random(seed) % 200; // Settling ringing
			end else if (hi) begin
				hsum = hsum + smp;
			end else begin
				lsum = lsum + smp;
			end
			adc_in = smp;
			credit_in = give;
			if (c % (2 * f) == 2 * f - 1) begin // Last clock of the period
				err = row.cfg.polarity ? lsum - hsum : hsum - lsum;
				err = err + row.cfg.err_offset;
				if (row.cfg.fb_on) begin
					step = step + (err >>> row.cfg.gain_sel_step);
				end else begin
					step = row.cfg.const_step;
				end
				ramp = ramp + (step >>> row.cfg.gain_sel_ramp);
				rec.step = step;
				rec.err = err;
				pend.push_back(rec);
				pend_ramp.push_back(ramp);
				pend_due.push_back(c + 2); // Demod and feedback registers
				hsum = 0;
				lsum = 0;
			end
			dac_exp = ramp_vis[`FOG_DAC_W-1:0] + (hi ? row.cfg.amp_h : row.cfg.amp_l);
			@(posedge clock_adc);
			#1;
		end
		check("final step", row.exp_step, u_dut.u_feedback.step_q);
		check("records left in FIFO", mq.size(), u_dut.u_rate_out.fill);
		$display("%s: %0d records received, overflow %0b, %0s", row.name, got, ovf,
			(n_errors == errs_before) ? "ok" : "errors");
	endtask

	initial begin
		int total;
		reset = 1'b1;
		cfg_in = '0;
		adc_in = '0;
		credit_in = 1'b0;
		seed = 32'h1d82;
		n_checks = 0;
		n_errors = 0;
		// freq, wait, polarity, offset, fb_on, step shift, const step, ramp shift
		rows[0] = '{"closed_loop", make_cfg(8, 2, 0, 0, 1, 2, 0, 4), 100, -50, 4, 1, 900};
		rows[1] = '{"polarity_flip", make_cfg(8, 2, 1, 0, 1, 2, 0, 4), 100, -50, 4, 1, -900};
		rows[2] = '{"open_loop", make_cfg(6, 1, 0, 37, 0, 0, 1234, 3), -20, 30, 5, 1, 1234};
		rows[3] = '{"credit_paced", make_cfg(5, 1, 0, -16, 1, 4, 0, 2), 300, 200, 6, 20, 144};
		rows[4] = '{"credit_withheld", make_cfg(4, 0, 0, 0, 1, 3, 0, 1), 10, 2, 8, 0, 32};
		total = 40;
		foreach (rows[i]) begin
			total += rows[i].periods * 2 * rows[i].cfg.freq_cnt + 20;
		end
		budget = total;
		for (r = 0; r < 5; r++) begin
			run_row(rows[r]);
		end
		n_errors += u_dut.u_asserts.fail_cnt; // Bound assertion failures
		$display("%0d checks, %0d errors", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+.
fog_pkg.sv
fog_loop_ctrl.sv
fog_demod.sv
fog_feedback.sv
fog_rate_out.sv
fog_top.sv
fog_asserts.sv
fog_tb.sv
